/* Bender.yml */
package:
  name: sdram_br

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - rtl/sdram_br_pkg.sv
  - rtl/br_ctrl.sv
  - rtl/beat_counter.sv
  - rtl/beat_shifter.sv
  - rtl/beat_mem.sv
  - rtl/sdram_br_top.sv

  # testbench, top module tb_sdram_br
  - target: test
    files:
      - tb/tb_sdram_br.sv

/* rtl/beat_counter.sv */
/*
 * beat index within the current word
 * holds at BEATS-1 after the last beat until the next clear
 */
`timescale 1ns/1ps

module beat_counter (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           clear,
	input  logic                           incr,
	output logic [sdram_br_pkg::IDX_W-1:0] idx,
	output logic                           last
);

	always_ff @(posedge clk) begin
		if (rst) begin
			idx <= '0;
		end else if (clear) begin
			idx <= '0;
		end else if (incr && !last) begin
			idx <= idx + 1'b1;
		end
	end

	// final beat of the word
	assign last = (idx == sdram_br_pkg::IDX_W'(sdram_br_pkg::BEATS - 1));

	// after the last beat completes, no further beat until a new word loads
	a_no_wrap: assert property (@(posedge clk) disable iff (rst)
		(incr && last) |=> (!incr until clear));

endmodule

/* rtl/beat_mem.sv */
/*
 * stand-in for the SDRAM controller, one beat at a time, no refresh
 * beat_done is high in the cycle ending ACCESS_CYCLES edges after the transfer
 * array has no reset, read only what was written; upper address bits alias
 */
`timescale 1ns/1ps

module beat_mem (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            beat_valid,
	input  sdram_br_pkg::beat_req_t         beat,
	output logic                            beat_ready,
	output logic                            beat_done,
	output logic [sdram_br_pkg::BEAT_W-1:0] beat_rdata
);

	logic [sdram_br_pkg::BEAT_W-1:0] mem [0:(2 ** sdram_br_pkg::MEM_AW) - 1];

	// latency countdown, zero marks the completing cycle
	logic [$clog2(sdram_br_pkg::ACCESS_CYCLES + 1)-1:0] timer;
	logic busy;

	// beat captured at transfer
	logic [sdram_br_pkg::MEM_AW-1:0] addr_q;
	logic [sdram_br_pkg::BEAT_W-1:0] wdata_q;
	logic is_write_q;

	logic xfer;

	assign xfer       = beat_valid && beat_ready;
	assign beat_ready = !busy;
	assign beat_done  = busy && (timer == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			timer <= '0;
		end else if (xfer) begin
			busy  <= 1'b1;
			timer <= ($bits(timer))'(sdram_br_pkg::ACCESS_CYCLES - 1);
		end else if (beat_done) begin
			// completion frees the store
			busy <= 1'b0;
		end else if (busy) begin
			timer <= timer - 1'b1;
		end
	end

	// only the low MEM_AW beat address bits are decoded
	always_ff @(posedge clk) begin
		if (xfer) begin
			addr_q     <= beat.addr[sdram_br_pkg::MEM_AW-1:0];
			wdata_q    <= beat.wdata;
			is_write_q <= (beat.cmd == sdram_br_pkg::CMD_WRITE);
		end
	end

	// write lands on the completing edge
	always_ff @(posedge clk) begin
		if (beat_done && is_write_q) begin
			mem[addr_q] <= wdata_q;
		end
	end

	// array cannot change while busy, so a read one edge after transfer
	// is already final by the done cycle
	always_ff @(posedge clk) begin
		if (busy) begin
			beat_rdata <= mem[addr_q];
		end
	end

	// every offered beat carries a real command
	a_cmd_valid: assert property (@(posedge clk) disable iff (rst)
		beat_valid |-> (beat.cmd != sdram_br_pkg::CMD_NONE));

endmodule

/* rtl/beat_shifter.sv */
/*
 * beat address generation and word serialize / assemble, low beat first
 * addr[1:0] ignored, misaligned requests are flagged, not handled
 * rdata of a write response reads as zero
 */
`timescale 1ns/1ps

module beat_shifter (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            load,
	input  logic                            shift,
	input  sdram_br_pkg::word_req_t         req,
	input  logic [sdram_br_pkg::IDX_W-1:0]  idx,
	input  logic [sdram_br_pkg::BEAT_W-1:0] beat_rdata,
	output logic                            write,
	output logic [31:0]                     beat_addr,
	output logic [sdram_br_pkg::BEAT_W-1:0] beat_wdata,
	output sdram_br_pkg::word_rsp_t         rsp
);

	// word aligned byte address
	logic [31:0] aligned_addr;
	// beat address of the low beat
	logic [31:0] base_q;
	logic [sdram_br_pkg::WORD_W-1:0] wdata_q;
	logic [sdram_br_pkg::WORD_W-1:0] rdata_q;

	assign aligned_addr = {req.addr[31:2], 2'b00};

	// request kind is control, everything else is payload
	always_ff @(posedge clk) begin
		if (rst) begin
			write <= 1'b0;
		end else if (load) begin
			write <= req.write;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			base_q  <= aligned_addr >> sdram_br_pkg::BEAT_SHIFT;
			wdata_q <= req.wdata;
			rdata_q <= '0;
		end else if (shift) begin
			// next write beat drops into the low bits
			wdata_q <= wdata_q >> sdram_br_pkg::BEAT_W;
			// read beat enters at the top, first beat ends lowest
			if (!write) begin
				rdata_q <= {beat_rdata,
					rdata_q[sdram_br_pkg::WORD_W-1:sdram_br_pkg::BEAT_W]};
			end
		end
	end

	// low beat at the base address, then upward
	assign beat_addr  = base_q + {{(32 - sdram_br_pkg::IDX_W){1'b0}}, idx};
	assign beat_wdata = wdata_q[sdram_br_pkg::BEAT_W-1:0];

	assign rsp = '{rdata: rdata_q, write: write};

	// word bus convention, byte address is 32-bit aligned
	a_aligned: assert property (@(posedge clk) disable iff (rst)
		load |-> (req.addr[1:0] == 2'b00));

endmodule

/* rtl/br_ctrl.sv */
/*
 * bridge FSM, one word in flight at a time
 * req_ready only in idle, so a stalled response also stalls new requests
 * beat_done is taken as the completion of the one outstanding beat
 */
`timescale 1ns/1ps

module br_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  logic                    beat_ready,
	input  logic                    beat_done,
	input  logic                    last,
	input  logic                    rsp_ready,
	input  logic                    write,
	output logic                    req_ready,
	output logic                    beat_valid,
	output logic                    rsp_valid,
	output logic                    load,
	output logic                    shift,
	output logic                    cnt_clear,
	output logic                    cnt_incr,
	output sdram_br_pkg::beat_cmd_e cmd
);

	sdram_br_pkg::br_state_e state;
	sdram_br_pkg::br_state_e state_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sdram_br_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			// wait for a word
			sdram_br_pkg::ST_IDLE: if (req_valid) state_next = sdram_br_pkg::ST_BEAT;
			// offer one beat to the store
			sdram_br_pkg::ST_BEAT: if (beat_ready) state_next = sdram_br_pkg::ST_WAIT;
			// beat in the store, last beat ends the word
			sdram_br_pkg::ST_WAIT: begin
				if (beat_done) begin
					state_next = last ? sdram_br_pkg::ST_RESP : sdram_br_pkg::ST_BEAT;
				end
			end
			// hold response until taken
			sdram_br_pkg::ST_RESP: if (rsp_ready) state_next = sdram_br_pkg::ST_IDLE;
			default: state_next = sdram_br_pkg::ST_IDLE;
		endcase
	end

	// handshakes straight from state
	assign req_ready  = (state == sdram_br_pkg::ST_IDLE);
	assign beat_valid = (state == sdram_br_pkg::ST_BEAT);
	assign rsp_valid  = (state == sdram_br_pkg::ST_RESP);

	// capture and counter clear on word accept
	assign load      = req_valid && req_ready;
	assign cnt_clear = load;

	// completed beat advances data path and index together
	assign shift    = (state == sdram_br_pkg::ST_WAIT) && beat_done;
	assign cnt_incr = shift;

	// command only while a beat is offered
	assign cmd = (state != sdram_br_pkg::ST_BEAT) ? sdram_br_pkg::CMD_NONE :
		(write ? sdram_br_pkg::CMD_WRITE : sdram_br_pkg::CMD_READ);

	// a raised word request stays up until the bridge takes it
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		(req_valid && !req_ready) |=> req_valid);

	// store completions only while a beat is outstanding
	a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
		beat_done |-> (state == sdram_br_pkg::ST_WAIT));

endmodule

/* rtl/sdram_br_pkg.sv */
/*
 * shared widths, latency and types for the word to beat bridge
 * only BEAT_W = 16 is exercised; 8 elaborates but is not checked
 * BEAT_SHIFT equals log2(BEATS), which matches the byte to beat shift only for 16
 */
package sdram_br_pkg;

	// word bus side
	localparam int WORD_W = 32;

	// memory port side, one beat per transfer
	localparam int BEAT_W = 16;
	localparam int BEATS = WORD_W / BEAT_W;

	// byte address of a word to beat address of its low beat
	localparam int BEAT_SHIFT = $clog2(BEATS);

	// beat index never narrower than one bit
	localparam int IDX_W = (BEATS > 1) ? $clog2(BEATS) : 1;

	// store decodes 2**MEM_AW beats, upper beat address bits alias
	localparam int MEM_AW = 10;

	// edges from beat transfer to beat completion, at least 2
	localparam int ACCESS_CYCLES = 3;

	// bridge controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_BEAT = 2'd1,
		ST_WAIT = 2'd2,
		ST_RESP = 2'd3
	} br_state_e;

	// beat command, same code points as the memory controller port
	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2
	} beat_cmd_e;

	// word request, addr is a byte address, low two bits ignored
	typedef struct packed {
		logic [31:0]       addr;
		logic [WORD_W-1:0] wdata;
		logic              write;
	} word_req_t;

	// word response, write echoes the request kind
	typedef struct packed {
		logic [WORD_W-1:0] rdata;
		logic              write;
	} word_rsp_t;

	// one beat toward the store, addr is a beat address
	typedef struct packed {
		beat_cmd_e         cmd;
		logic [31:0]       addr;
		logic [BEAT_W-1:0] wdata;
	} beat_req_t;

endpackage

/* rtl/sdram_br_top.sv */
/*
 * word bus to beat store bridge with the backing store attached
 * one word in flight, response back-pressure stalls requests
 */
`timescale 1ns/1ps

module sdram_br_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  sdram_br_pkg::word_req_t req,
	input  logic                    rsp_ready,
	output logic                    req_ready,
	output logic                    rsp_valid,
	output sdram_br_pkg::word_rsp_t rsp
);

	// control between FSM, counter and data path
	logic load;
	logic shift;
	logic cnt_clear;
	logic cnt_incr;
	logic last;
	logic write;
	logic [sdram_br_pkg::IDX_W-1:0] idx;

	// beat channel
	sdram_br_pkg::beat_cmd_e cmd;
	sdram_br_pkg::beat_req_t beat;
	logic beat_valid;
	logic beat_ready;
	logic beat_done;
	logic [31:0] beat_addr;
	logic [sdram_br_pkg::BEAT_W-1:0] beat_wdata;
	logic [sdram_br_pkg::BEAT_W-1:0] beat_rdata;

	assign beat = '{cmd: cmd, addr: beat_addr, wdata: beat_wdata};

	br_ctrl br_ctrl_i (
		.clk, .rst, .req_valid, .beat_ready, .beat_done, .last, .rsp_ready, .write,
		.req_ready, .beat_valid, .rsp_valid, .load, .shift, .cnt_clear, .cnt_incr, .cmd
	);

	beat_counter beat_counter_i (
		.clk, .rst, .clear(cnt_clear), .incr(cnt_incr), .idx, .last
	);

	beat_shifter beat_shifter_i (
		.clk, .rst, .load, .shift, .req, .idx, .beat_rdata,
		.write, .beat_addr, .beat_wdata, .rsp
	);

	beat_mem beat_mem_i (
		.clk, .rst, .beat_valid, .beat, .beat_ready, .beat_done, .beat_rdata
	);

endmodule

/* src.f */
rtl/sdram_br_pkg.sv
rtl/br_ctrl.sv
rtl/beat_counter.sv
rtl/beat_shifter.sv
rtl/beat_mem.sv
rtl/sdram_br_top.sv
tb/tb_sdram_br.sv

/* tb/tb_sdram_br.sv */
/*
 * random word traffic against a reference model of the beat store
 * reads only hit words already written, the store has no reset contents
 * model key keeps only the decoded address bits, so high tags alias
 */
`timescale 1ns/1ps

module tb_sdram_br;

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DLY = 1;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT = 200;
	localparam int NUM_OPS = 300;
	// edges from word accept to the first edge that sees rsp_valid
	localparam int RSP_LATENCY =
		1 + sdram_br_pkg::BEATS * (sdram_br_pkg::ACCESS_CYCLES + 1);

	logic clk;
	logic rst;
	logic req_valid;
	sdram_br_pkg::word_req_t req;
	logic rsp_ready;
	logic req_ready;
	logic rsp_valid;
	sdram_br_pkg::word_rsp_t rsp;

	logic [31:0] lcg_state;
	// reference store, one entry per decoded word
	logic [31:0] model [int unsigned];
	int errors;
	int checks;
	bit hung;

	sdram_br_top sdram_br_top_i (
		.clk, .rst, .req_valid, .req, .rsp_ready, .req_ready, .rsp_valid, .rsp
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// byte address to decoded word index
	function automatic int unsigned word_key(input logic [31:0] addr);
		return (addr >> 2) & ((32'd1 << (sdram_br_pkg::MEM_AW - sdram_br_pkg::BEAT_SHIFT)) - 1);
	endfunction

	// all driving and sampling sits just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] got);
		errors++;
		$display("ERROR %0t %s: expected %0h got %0h", $time, name, exp, got);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		hung = 1'b1;
		$display("gave up after %0d cycles waiting for %s", TIMEOUT, what);
	endtask

	// one word through the bridge, request to taken response
	task automatic run_word(input logic wr, input logic [31:0] addr, input logic [31:0] data,
		input int delay, input logic bp, input int hold);
		int wait_cnt;
		int lat;
		logic [31:0] exp_rdata;
		sdram_br_pkg::word_rsp_t held;

		// back-pressure words keep rsp_ready low until the hold ends
		rsp_ready = !bp;
		repeat (delay) next_cycle();
		req_valid = 1'b1;
		req = '{addr: addr, wdata: data, write: wr};
		exp_rdata = model.exists(word_key(addr)) ? model[word_key(addr)] : 32'h0;

		wait_cnt = 0;
		while (!req_ready && wait_cnt < TIMEOUT) begin
			next_cycle();
			wait_cnt++;
		end
		if (!req_ready) begin
			report_timeout("req_ready");
			return;
		end

		// transfer on this edge
		next_cycle();
		req_valid = 1'b0;
		// scrambled payload, only the captured copy may be used
		req = '{addr: addr ^ 32'h0000_0ff0, wdata: ~data, write: !wr};
		if (wr) begin
			model[word_key(addr)] = data;
		end
		if (req_ready !== 1'b0) report_mismatch("req_ready", 0, req_ready);

		lat = 1;
		while (!rsp_valid && lat <= TIMEOUT) begin
			next_cycle();
			lat++;
		end
		if (!rsp_valid) begin
			report_timeout("rsp_valid");
			return;
		end

		checks++;
		held = rsp;
		if (!bp && lat != RSP_LATENCY) report_mismatch("rsp_valid latency", RSP_LATENCY, lat);
		if (rsp.write !== wr) report_mismatch("rsp.write", wr, rsp.write);
		if (!wr && rsp.rdata !== exp_rdata) report_mismatch("rsp.rdata", exp_rdata, rsp.rdata);

		// stalled response stays put and blocks new words
		if (bp) begin
			repeat (hold) begin
				next_cycle();
				if (rsp_valid !== 1'b1) report_mismatch("rsp_valid", 1, rsp_valid);
				if (req_ready !== 1'b0) report_mismatch("req_ready", 0, req_ready);
				if (rsp !== held) report_mismatch("rsp", held, rsp);
			end
			rsp_ready = 1'b1;
		end

		// response taken on this edge, exactly one per word
		next_cycle();
		if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 0, rsp_valid);
		if (req_ready !== 1'b1) report_mismatch("req_ready", 1, req_ready);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		logic wr;

		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		lcg_state = 32'hbd8a_2ac0;
		errors = 0;
		checks = 0;
		hung = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		// idle bridge after reset
		if (req_ready !== 1'b1) report_mismatch("req_ready", 1, req_ready);
		if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 0, rsp_valid);

		// two tags on one decoded word, the later write wins
		run_word(1'b1, 32'h0000_0040, 32'h1111_2222, 0, 1'b0, 0);
		if (!hung) run_word(1'b1, 32'h0045_0040, 32'hcafe_f00d, 1, 1'b0, 0);
		if (!hung) run_word(1'b0, 32'h0000_0040, 32'h0, 0, 1'b1, 3);

		for (int i = 0; i < NUM_OPS && !hung; i++) begin
			r = next_rand();
			wr = r[31];
			// 64 word pool, tag in bits 21:20 lands above the decoded range
			addr = (32'(r[24:23]) << 20) | (32'(r[30:25]) << 2);
			// never read a word the store has not seen
			if (!model.exists(word_key(addr))) wr = 1'b1;
			run_word(wr, addr, next_rand(), int'(r[22:21]), r[20], int'(r[19:17]) + 1);
		end

		$display("responses checked %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
